/* src/scache_pkg.sv */
package scache_pkg;

   localparam int SCACHE_DWID       = 32;
   localparam int SCACHE_BANK_WORDS = 64;
   localparam int SCACHE_NUM_BANKS  = 2;

   // byte address covering all banks, 512 bytes
   localparam int SCACHE_ADDR_W =
      $clog2(SCACHE_NUM_BANKS * SCACHE_BANK_WORDS * (SCACHE_DWID / 8));

   localparam int SCACHE_WIDX_W = $clog2(SCACHE_BANK_WORDS);

   typedef logic [SCACHE_DWID-1:0]     data_t;
   typedef logic [SCACHE_DWID/8-1:0]   be_t;

   // [8] bank, [7:2] word index, [1:0] byte offset
   typedef logic [SCACHE_ADDR_W-1:0]   byte_addr_t;

   // one bit wider than the address, sum wraps modulo 512
   typedef logic [SCACHE_ADDR_W:0]     gap_t;

   typedef logic [SCACHE_WIDX_W-1:0]   word_idx_t;

   // code 3 reads as byte and writes as word
   typedef enum logic [1:0] {
      SIZE_WORD = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_BYTE = 2'd2
   } access_size_e;

endpackage

/* src/scache_stride_agu.sv */
`timescale 1ns/1ns

module scache_stride_agu
   import scache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start,
   input  byte_addr_t dst_addr,
   input  byte_addr_t sub_len,
   input  byte_addr_t sub_gap,
   input  byte_addr_t sys_len,
   input  gap_t       sys_gap,
   input  logic       step,
   output byte_addr_t addr,
   output logic       active,
   output logic       last
);

   byte_addr_t sub_cnt;        // word within current run
   byte_addr_t sys_cnt;        // run number
   byte_addr_t sub_last_idx;
   byte_addr_t sys_last_idx;
   byte_addr_t sub_gap_r;
   gap_t       sys_gap_r;
   logic       run_end;
   logic       advance;

   assign run_end = (sub_cnt == sub_last_idx);
   assign last    = active && run_end && (sys_cnt == sys_last_idx);
   assign advance = active && step;

   // stride config captured with the command
   always_ff @(posedge clk) begin
      if (start) begin
         sub_last_idx <= sub_len - 1'b1;   // 0 wraps to 511, a 512-word run
         sys_last_idx <= sys_len - 1'b1;
         sub_gap_r    <= sub_gap;
         sys_gap_r    <= sys_gap;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active  <= 1'b0;
         addr    <= '0;
         sub_cnt <= '0;
         sys_cnt <= '0;
      end else if (start) begin
         active  <= 1'b1;
         addr    <= dst_addr;
         sub_cnt <= '0;
         sys_cnt <= '0;
      end else if (advance) begin
         if (last) begin
            active <= 1'b0;
         end else if (run_end) begin
            sub_cnt <= '0;
            sys_cnt <= sys_cnt + 1'b1;
            addr    <= byte_addr_t'(addr + sys_gap_r);   // outer jump from run end
         end else begin
            sub_cnt <= sub_cnt + 1'b1;
            addr    <= addr + sub_gap_r;
         end
      end
   end

   // once the final address is consumed the generator stays quiet
   a_last_ends: assert property (@(posedge clk) disable iff (!rst_n)
      (step && last && !start) |=> (!active && !last));

endmodule

/* src/scache_wr_pack.sv */
`timescale 1ns/1ns

module scache_wr_pack
   import scache_pkg::*;
(
   input  access_size_e size,
   input  logic [1:0]   offset,
   input  data_t        data,
   output data_t        lane_data,
   output be_t          mask
);

   always_comb begin
      case (size)
         SIZE_BYTE: begin
            lane_data = data_t'(data[7:0]) << {offset, 3'b000};
            mask      = be_t'(4'b0001) << offset;            // one lane
         end
         SIZE_HALF: begin
            lane_data = data_t'(data[15:0]) << {offset[1], 4'b0000};
            mask      = be_t'(4'b0011) << {offset[1], 1'b0};  // low or high half
         end
         default: begin
            // word, and the unused code 3
            lane_data = data;
            mask      = '1;
         end
      endcase
   end

endmodule

/* src/scache_bank_arb.sv */
`timescale 1ns/1ns

module scache_bank_arb
   import scache_pkg::*;
(
   input  byte_addr_t      wr_addr,
   input  byte_addr_t      rd_addr,
   input  logic            wr_go,
   input  logic            rd_active,
   input  logic            rd_ready,
   input  data_t           lane_data,
   input  be_t             mask,
   output logic            rd_stall,
   output logic            rd_launch,
   output logic [1:0]      bank_en,
   output logic [1:0]      bank_we,
   output word_idx_t [1:0] bank_addr,
   output data_t [1:0]     bank_wdata,
   output be_t [1:0]       bank_mask
);

   logic [1:0] wr_sel;     // write hits this bank
   logic [1:0] rd_sel;     // pending read hits this bank
   logic       conflict;

   always_comb begin
      for (int b = 0; b < SCACHE_NUM_BANKS; b++) begin
         wr_sel[b] = wr_go && (wr_addr[SCACHE_ADDR_W-1] == 1'(b));
         rd_sel[b] = rd_active && (rd_addr[SCACHE_ADDR_W-1] == 1'(b));
      end

      // write wins and the read waits a cycle
      conflict  = |(wr_sel & rd_sel);
      rd_stall  = conflict || !rd_ready;
      rd_launch = rd_active && !rd_stall;

      for (int b = 0; b < SCACHE_NUM_BANKS; b++) begin
         bank_en[b]    = wr_sel[b] || (rd_sel[b] && rd_launch);
         bank_we[b]    = wr_sel[b];
         bank_addr[b]  = wr_sel[b] ? wr_addr[SCACHE_ADDR_W-2:2] : rd_addr[SCACHE_ADDR_W-2:2];
         bank_wdata[b] = lane_data;
         bank_mask[b]  = wr_sel[b] ? mask : '0;
      end
   end

endmodule

/* src/scache_sram_bank.sv */
`timescale 1ns/1ns

module scache_sram_bank
   import scache_pkg::*;
(
   input  logic      clk,
   input  logic      en,
   input  logic      we,
   input  word_idx_t addr,
   input  data_t     wdata,
   input  be_t       mask,
   output data_t     rdata
);

   data_t mem [SCACHE_BANK_WORDS];

   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int i = 0; i < SCACHE_DWID / 8; i++) begin
            if (mask[i]) begin
               mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
      end
      // rdata only moves on a read, so writes leave it alone
      if (en && !we) begin
         rdata <= mem[addr];
      end
   end

endmodule

/* src/scache_rd_unpack.sv */
`timescale 1ns/1ns

module scache_rd_unpack
   import scache_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         launch,
   input  logic         launch_bank,
   input  logic         launch_last,
   input  logic [1:0]   launch_offset,
   input  access_size_e size,
   input  logic         sign_ext,
   input  data_t [1:0]  bank_rdata,
   input  logic         rd_ready,
   output logic         rd_valid,
   output logic         rd_last,
   output data_t        rd_data
);

   logic       s1_valid;   // ram stage holds a beat
   logic       s1_last;
   logic       s1_bank;
   logic [1:0] s1_offset;
   data_t      raw;
   data_t      ext;
   logic [15:0] half_v;
   logic [7:0]  byte_v;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
         s1_last  <= 1'b0;
         rd_valid <= 1'b0;
         rd_last  <= 1'b0;
      end else if (rd_ready) begin
         s1_valid <= launch;
         s1_last  <= launch && launch_last;
         rd_valid <= s1_valid;
         rd_last  <= s1_last;
      end
   end

   // lane info follows the address into the ram stage
   always_ff @(posedge clk) begin
      if (launch) begin
         s1_bank   <= launch_bank;
         s1_offset <= launch_offset;
      end
   end

   assign raw    = s1_bank ? bank_rdata[1] : bank_rdata[0];
   assign half_v = s1_offset[1] ? raw[31:16] : raw[15:0];
   assign byte_v = raw[{s1_offset, 3'b000} +: 8];

   always_comb begin
      case (size)
         SIZE_WORD: ext = raw;
         SIZE_HALF: ext = {{16{sign_ext & half_v[15]}}, half_v};
         default:   ext = {{24{sign_ext & byte_v[7]}}, byte_v};   // byte, also code 3
      endcase
   end

   always_ff @(posedge clk) begin
      if (rd_ready && s1_valid) begin
         rd_data <= ext;
      end
   end

   // a stalled beat is held until the sink takes it
   a_hold_beat: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_valid && !rd_ready) |=> ($stable(rd_valid) && $stable(rd_data) && $stable(rd_last)));

endmodule

/* src/scache_cflow_top.sv */
`timescale 1ns/1ns

module scache_cflow_top
   import scache_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         wr_en,
   input  logic         wr_valid,
   input  data_t        wr_data,
   input  byte_addr_t   wr_dst_addr,
   input  access_size_e wr_size,
   input  byte_addr_t   wr_sub_len,
   input  byte_addr_t   wr_sub_gap,
   input  byte_addr_t   wr_sys_len,
   input  gap_t         wr_sys_gap,
   output logic         wr_done,
   input  logic         rd_en,
   input  logic         rd_sign_ext,
   input  byte_addr_t   rd_dst_addr,
   input  access_size_e rd_size,
   input  byte_addr_t   rd_sub_len,
   input  byte_addr_t   rd_sub_gap,
   input  byte_addr_t   rd_sys_len,
   input  gap_t         rd_sys_gap,
   input  logic         rd_ready,
   output logic         rd_valid,
   output logic         rd_last,
   output logic         rd_idle,
   output data_t        rd_data
);

   byte_addr_t      wr_addr, rd_addr;
   logic            wr_active, rd_active;
   logic            wr_addr_last, rd_addr_last;
   logic            wr_go;
   logic            rd_stall, rd_launch;
   data_t           lane_data;
   be_t             lane_mask;
   logic [1:0]      bank_en, bank_we;
   word_idx_t [1:0] bank_addr;
   data_t [1:0]     bank_wdata;
   be_t [1:0]       bank_mask;
   data_t           bank0_rdata, bank1_rdata;
   access_size_e    wr_size_r, rd_size_r;
   logic            rd_sign_ext_r;

   assign wr_go   = wr_valid && wr_active;     // no ready, every valid word lands
   assign wr_done = wr_go && wr_addr_last;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_size_r     <= SIZE_WORD;
         rd_size_r     <= SIZE_WORD;
         rd_sign_ext_r <= 1'b0;
         rd_idle       <= 1'b1;
      end else begin
         if (wr_en) begin
            wr_size_r <= wr_size;
         end
         if (rd_en) begin
            rd_size_r     <= rd_size;
            rd_sign_ext_r <= rd_sign_ext;
            rd_idle       <= 1'b0;
         end else if (rd_valid && rd_ready && rd_last) begin
            rd_idle <= 1'b1;   // final beat taken
         end
      end
   end

   scache_stride_agu u_wr_agu (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (wr_en),
      .dst_addr (wr_dst_addr),
      .sub_len  (wr_sub_len),
      .sub_gap  (wr_sub_gap),
      .sys_len  (wr_sys_len),
      .sys_gap  (wr_sys_gap),
      .step     (wr_valid),
      .addr     (wr_addr),
      .active   (wr_active),
      .last     (wr_addr_last)
   );

   scache_stride_agu u_rd_agu (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (rd_en),
      .dst_addr (rd_dst_addr),
      .sub_len  (rd_sub_len),
      .sub_gap  (rd_sub_gap),
      .sys_len  (rd_sys_len),
      .sys_gap  (rd_sys_gap),
      .step     (!rd_stall),
      .addr     (rd_addr),
      .active   (rd_active),
      .last     (rd_addr_last)
   );

   scache_wr_pack u_wr_pack (
      .size      (wr_size_r),
      .offset    (wr_addr[1:0]),
      .data      (wr_data),
      .lane_data (lane_data),
      .mask      (lane_mask)
   );

   scache_bank_arb u_bank_arb (
      .wr_addr    (wr_addr),
      .rd_addr    (rd_addr),
      .wr_go      (wr_go),
      .rd_active  (rd_active),
      .rd_ready   (rd_ready),
      .lane_data  (lane_data),
      .mask       (lane_mask),
      .rd_stall   (rd_stall),
      .rd_launch  (rd_launch),
      .bank_en    (bank_en),
      .bank_we    (bank_we),
      .bank_addr  (bank_addr),
      .bank_wdata (bank_wdata),
      .bank_mask  (bank_mask)
   );

   scache_sram_bank u_bank0 (
      .clk   (clk),
      .en    (bank_en[0]),
      .we    (bank_we[0]),
      .addr  (bank_addr[0]),
      .wdata (bank_wdata[0]),
      .mask  (bank_mask[0]),
      .rdata (bank0_rdata)
   );

   scache_sram_bank u_bank1 (
      .clk   (clk),
      .en    (bank_en[1]),
      .we    (bank_we[1]),
      .addr  (bank_addr[1]),
      .wdata (bank_wdata[1]),
      .mask  (bank_mask[1]),
      .rdata (bank1_rdata)
   );

   scache_rd_unpack u_rd_unpack (
      .clk           (clk),
      .rst_n         (rst_n),
      .launch        (rd_launch),
      .launch_bank   (rd_addr[SCACHE_ADDR_W-1]),
      .launch_last   (rd_addr_last),
      .launch_offset (rd_addr[1:0]),
      .size          (rd_size_r),
      .sign_ext      (rd_sign_ext_r),
      .bank_rdata    ({bank1_rdata, bank0_rdata}),
      .rd_ready      (rd_ready),
      .rd_valid      (rd_valid),
      .rd_last       (rd_last),
      .rd_data       (rd_data)
   );

endmodule

/* dv/scache_clk_gen.sv */
`timescale 1ns/1ns

module scache_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   // reset held low for 8 cycles, released on a falling edge
   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

/* dv/scache_ref.svh */
`ifndef SCACHE_REF_SVH
`define SCACHE_REF_SVH

// byte image of both banks, little endian within a word
logic [7:0] ref_mem [2**SCACHE_ADDR_W];

// k-th address of a two-level stride transfer
function automatic byte_addr_t ref_stride_addr(input byte_addr_t start, input byte_addr_t sub_len,
                                               input byte_addr_t sub_gap, input gap_t sys_gap,
                                               input int k);
   int run_words;
   int run;
   int idx;
   int a;
   run_words = (sub_len == 0) ? 512 : int'(sub_len);
   run       = k / run_words;
   idx       = k % run_words;
   // each run spans (len-1) inner gaps, then the outer gap
   a = int'(start) + run * (int'(sub_gap) * (run_words - 1) + int'(sys_gap))
       + idx * int'(sub_gap);
   return byte_addr_t'(a);   // wraps modulo 512
endfunction

function automatic void ref_write(input byte_addr_t addr, input access_size_e size,
                                  input data_t data);
   int base;
   base = int'({addr[8:2], 2'b00});
   case (size)
      SIZE_BYTE: ref_mem[base + int'(addr[1:0])] = data[7:0];
      SIZE_HALF: begin
         ref_mem[base + 2 * int'(addr[1])]     = data[7:0];
         ref_mem[base + 2 * int'(addr[1]) + 1] = data[15:8];
      end
      default: begin
         for (int i = 0; i < 4; i++) ref_mem[base + i] = data[8*i +: 8];   // code 3 too
      end
   endcase
endfunction

function automatic data_t ref_read(input byte_addr_t addr, input access_size_e size,
                                   input logic sign_ext);
   int          base;
   logic [15:0] h;
   logic [7:0]  b;
   base = int'({addr[8:2], 2'b00});
   h    = {ref_mem[base + 2 * int'(addr[1]) + 1], ref_mem[base + 2 * int'(addr[1])]};
   b    = ref_mem[base + int'(addr[1:0])];
   case (size)
      SIZE_WORD: return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
      SIZE_HALF: return sign_ext ? {{16{h[15]}}, h} : {16'h0000, h};
      default:   return sign_ext ? {{24{b[7]}}, b} : {24'h000000, b};
   endcase
endfunction

`endif

/* dv/scache_cflow_tb.sv */
`timescale 1ns/1ns

module scache_cflow_tb
   import scache_pkg::*;
();

   logic         clk, rst_n;
   logic         wr_en, wr_valid, wr_done;
   data_t        wr_data;
   byte_addr_t   wr_dst_addr, wr_sub_len, wr_sub_gap, wr_sys_len;
   gap_t         wr_sys_gap;
   access_size_e wr_size;
   logic         rd_en, rd_sign_ext, rd_ready, rd_valid, rd_last, rd_idle;
   data_t        rd_data;
   byte_addr_t   rd_dst_addr, rd_sub_len, rd_sub_gap, rd_sys_len;
   gap_t         rd_sys_gap;
   access_size_e rd_size;

   data_t exp_data_q[$];      // expected beats in order
   logic  exp_last_q[$];
   data_t head_data;
   logic  head_last;
   int    beat_cnt    = 0;
   int    wr_done_cnt = 0;
   int    wr_cmd_cnt  = 0;
   logic  ready_toggle = 1'b0;

   `include "scache_ref.svh"

   scache_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   scache_cflow_top u_dut (
      .clk(clk), .rst_n(rst_n),
      .wr_en(wr_en), .wr_valid(wr_valid), .wr_data(wr_data), .wr_dst_addr(wr_dst_addr),
      .wr_size(wr_size), .wr_sub_len(wr_sub_len), .wr_sub_gap(wr_sub_gap),
      .wr_sys_len(wr_sys_len), .wr_sys_gap(wr_sys_gap), .wr_done(wr_done),
      .rd_en(rd_en), .rd_sign_ext(rd_sign_ext), .rd_dst_addr(rd_dst_addr), .rd_size(rd_size),
      .rd_sub_len(rd_sub_len), .rd_sub_gap(rd_sub_gap), .rd_sys_len(rd_sys_len),
      .rd_sys_gap(rd_sys_gap), .rd_ready(rd_ready), .rd_valid(rd_valid), .rd_last(rd_last),
      .rd_idle(rd_idle), .rd_data(rd_data)
   );

   task automatic fail_stop();
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
         fail_stop();
      end
   endtask

   task automatic check_last(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         fail_stop();
      end
   endtask

   task automatic check_done(input int got, input int exp);
      if (got != exp) begin
         $display("Error at %0t ns: wr_done pulsed %0d times for %0d writes", $time, got, exp);
         fail_stop();
      end
   endtask

   task automatic check_beats(input int got, input int exp);
      if (got != exp) begin
         $display("Error at %0t ns: read gave %0d beats, expected %0d", $time, got, exp);
         fail_stop();
      end
   endtask

   // sink ready is random while toggling is on
   always @(negedge clk) begin
      rd_ready = ready_toggle ? (($urandom % 3) != 0) : 1'b1;
   end

   always @(posedge clk) begin
      if (rst_n && wr_done) wr_done_cnt++;
   end

   // compare every transferred beat with the head of the queue
   always @(posedge clk) begin
      if (rst_n && rd_valid && rd_ready) begin
         if (exp_data_q.size() == 0) begin
            $display("A read beat arrived at %0t ns with none expected", $time);
            fail_stop();
         end
         head_data = exp_data_q.pop_front();
         head_last = exp_last_q.pop_front();
         check_data(rd_data, head_data, $sformatf("read beat %0d", beat_cnt));
         check_last(rd_last, head_last, $sformatf("rd_last of beat %0d", beat_cnt));
         beat_cnt++;
      end
   end

   task automatic write_stream(input byte_addr_t start, input access_size_e size,
                               input byte_addr_t sub_len, input byte_addr_t sub_gap,
                               input byte_addr_t sys_len, input gap_t sys_gap, input logic idles);
      int    total;
      int    cycles;
      data_t d;
      total = ((sub_len == 0) ? 512 : int'(sub_len)) * int'(sys_len);
      @(negedge clk);
      wr_en       = 1'b1;
      wr_dst_addr = start;
      wr_size     = size;
      wr_sub_len  = sub_len;
      wr_sub_gap  = sub_gap;
      wr_sys_len  = sys_len;
      wr_sys_gap  = sys_gap;
      wr_cmd_cnt++;
      @(negedge clk);
      wr_en = 1'b0;
      for (int k = 0; k < total; k++) begin
         if (idles && ($urandom % 4 == 0)) begin   // bubble in the stream
            wr_valid = 1'b0;
            @(negedge clk);
         end
         d        = $urandom;
         wr_valid = 1'b1;
         wr_data  = d;
         ref_write(ref_stride_addr(start, sub_len, sub_gap, sys_gap, k), size, d);
         @(negedge clk);
      end
      wr_valid = 1'b0;
      cycles   = 0;
      while (wr_done_cnt < wr_cmd_cnt) begin
         @(negedge clk);
         cycles++;
         if (cycles > 10) begin
            $display("Timeout: wr_done never pulsed for the write at %0t ns", $time);
            fail_stop();
         end
      end
      check_done(wr_done_cnt, wr_cmd_cnt);
   endtask

   task automatic read_stream(input byte_addr_t start, input access_size_e size, input logic sign,
                              input byte_addr_t sub_len, input byte_addr_t sub_gap,
                              input byte_addr_t sys_len, input gap_t sys_gap);
      int total;
      int beats_before;
      int cycles;
      total = ((sub_len == 0) ? 512 : int'(sub_len)) * int'(sys_len);
      for (int k = 0; k < total; k++) begin
         exp_data_q.push_back(ref_read(ref_stride_addr(start, sub_len, sub_gap, sys_gap, k),
                                       size, sign));
         exp_last_q.push_back(k == total - 1);
      end
      beats_before = beat_cnt;
      @(negedge clk);
      rd_en       = 1'b1;
      rd_dst_addr = start;
      rd_size     = size;
      rd_sign_ext = sign;
      rd_sub_len  = sub_len;
      rd_sub_gap  = sub_gap;
      rd_sys_len  = sys_len;
      rd_sys_gap  = sys_gap;
      @(negedge clk);
      rd_en  = 1'b0;
      cycles = 0;
      while (!rd_idle) begin
         @(negedge clk);
         cycles++;
         if (cycles > 20 * total + 100) begin
            $display("Timeout: rd_idle did not return high after a read of %0d beats", total);
            fail_stop();
         end
      end
      check_beats(beat_cnt - beats_before, total);
   endtask

   initial begin
      byte_addr_t len_a;
      byte_addr_t len_b;
      int         cycles;
      void'($urandom(32'h8848));
      {wr_en, wr_valid, rd_en, rd_sign_ext} = '0;
      rd_ready    = 1'b1;
      wr_data     = '0;
      wr_size     = SIZE_WORD;
      rd_size     = SIZE_WORD;
      {wr_dst_addr, wr_sub_len, wr_sub_gap, wr_sys_len} = '0;
      {rd_dst_addr, rd_sub_len, rd_sub_gap, rd_sys_len} = '0;
      wr_sys_gap  = '0;
      rd_sys_gap  = '0;
      cycles      = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles > 20) begin
            $display("Timeout: reset was never released");
            fail_stop();
         end
      end
      check_last(wr_done, 1'b0, "wr_done after reset");
      check_last(rd_valid, 1'b0, "rd_valid after reset");
      check_last(rd_last, 1'b0, "rd_last after reset");
      check_last(rd_idle, 1'b1, "rd_idle after reset");

      // fill both banks with words and read back the same way
      write_stream(9'h000, SIZE_WORD, 9'd128, 9'd4, 9'd1, 10'd0, 1'b1);
      read_stream(9'h000, SIZE_WORD, 1'b0, 9'd128, 9'd4, 9'd1, 10'd0);

      // narrow writes merging into words
      write_stream(9'h040, SIZE_BYTE, 9'd16, 9'd1, 9'd1, 10'd0, 1'b0);
      write_stream(9'h052, SIZE_HALF, 9'd8, 9'd2, 9'd1, 10'd0, 1'b1);
      write_stream(9'h061, SIZE_BYTE, 9'd6, 9'd3, 9'd1, 10'd0, 1'b0);
      read_stream(9'h040, SIZE_WORD, 1'b0, 9'd13, 9'd4, 9'd1, 10'd0);

      // narrow reads of every lane with zero and sign extension
      for (int s = 0; s < 2; s++) begin
         read_stream(9'h040, SIZE_BYTE, 1'(s), 9'd16, 9'd1, 9'd1, 10'd0);
         read_stream(9'h050, SIZE_HALF, 1'(s), 9'd8, 9'd2, 9'd1, 10'd0);
         read_stream(9'h1fc, SIZE_BYTE, 1'(s), 9'd8, 9'd1, 9'd1, 10'd0);   // wraps to 0
      end

      // random strides with one full 512-word run first
      for (int n = 0; n < 6; n++) begin
         len_a = (n == 0) ? 9'd0 : byte_addr_t'(1 + $urandom % 24);
         len_b = (n == 0) ? 9'd1 : byte_addr_t'(1 + $urandom % 5);
         if (n == 3) begin
            write_stream(byte_addr_t'($urandom), SIZE_WORD, len_a, byte_addr_t'($urandom),
                         len_b, gap_t'($urandom), 1'b1);
         end
         read_stream(byte_addr_t'($urandom), access_size_e'($urandom % 3), 1'($urandom),
                     len_a, byte_addr_t'($urandom), len_b, gap_t'($urandom));
      end

      // back-pressure from the sink
      ready_toggle <= 1'b1;
      read_stream(9'h000, SIZE_WORD, 1'b0, 9'd128, 9'd4, 9'd1, 10'd0);
      read_stream(9'h0a6, SIZE_HALF, 1'b1, 9'd5, 9'd6, 9'd4, 10'd300);
      ready_toggle <= 1'b0;

      // bank 0 write against a bank 0 read of other words
      fork
         write_stream(9'h000, SIZE_WORD, 9'd32, 9'd4, 9'd1, 10'd0, 1'b1);
         read_stream(9'h080, SIZE_WORD, 1'b0, 9'd32, 9'd4, 9'd1, 10'd0);
      join
      read_stream(9'h000, SIZE_WORD, 1'b0, 9'd32, 9'd4, 9'd1, 10'd0);

      @(negedge clk);
      if (exp_data_q.size() == 0 && wr_done_cnt == wr_cmd_cnt) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("Expected beats were left over or write done pulses are missing at the end");
         fail_stop();
      end
   end

endmodule

/* scache_cflow.f */
+incdir+dv
src/scache_pkg.sv
src/scache_stride_agu.sv
src/scache_wr_pack.sv
src/scache_bank_arb.sv
src/scache_sram_bank.sv
src/scache_rd_unpack.sv
src/scache_cflow_top.sv
dv/scache_clk_gen.sv
dv/scache_cflow_tb.sv
